// ==== src/memGeomPkg.sv ====
package memGeomPkg;

  // data word width.
  localparam int wordBits = 64;

  // byte lanes per word.
  localparam int laneCount = 8;

  // bits per lane.
  localparam int laneBits = wordBits / laneCount;

  // words held by the data RAM.
  localparam int ramDepth = 256;

  // word index width.
  localparam int indexBits = $clog2(ramDepth);

  // byte offset inside a word.
  localparam int offsetBits = $clog2(laneCount);

  // request address width, only index and offset are decoded.
  localparam int addrBits = 64;

  // one write enable per byte lane.
  typedef logic [laneCount-1:0] byteMask;

endpackage

// ==== src/lsuPkg.sv ====
package lsuPkg;

  // memory opcode, load encoding.
  // bit 2 selects zero extension, bits 1:0 give the size.
  // stores only look at the size bits.
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    ld  = 3'b011,
    lbu = 3'b100,
    lhu = 3'b101,
    lwu = 3'b110
  } memOp;

  // access request from the core.
  // held for one cycle per access.
  typedef struct packed {
    logic                                rd;
    logic                                wr;
    memOp                                op;
    logic [memGeomPkg::addrBits-1:0]     addr;
    logic [memGeomPkg::wordBits-1:0]     wdata;
  } lsuReq;

  // one aligned write into the RAM.
  typedef struct packed {
    logic                                we;
    logic [memGeomPkg::indexBits-1:0]    index;
    memGeomPkg::byteMask                 mask;
    logic [memGeomPkg::wordBits-1:0]     data;
  } storeBeat;

  // offset bits that must be zero for the access size.
  // byte 000, half 001, word 011, double 111.
  function automatic logic [memGeomPkg::offsetBits-1:0] alignMask(memOp op);
    logic [memGeomPkg::offsetBits:0] sizeBytes;
    sizeBytes = '0;
    sizeBytes[op[1:0]] = 1'b1;
    return memGeomPkg::offsetBits'(sizeBytes - 1'b1);
  endfunction

endpackage

// ==== src/storeAlign.sv ====
`timescale 1ns/1ns

module storeAlign (
  input  lsuPkg::lsuReq    req,
  output lsuPkg::storeBeat beat
);

  // byte position inside the addressed word.
  logic [memGeomPkg::offsetBits-1:0] offset;
  // offset bits covered by the access size.
  logic [memGeomPkg::offsetBits-1:0] sizeMask;
  // store size in the load encoding.
  lsuPkg::memOp                      sizeOp;
  logic [memGeomPkg::wordBits-1:0]   repData;
  memGeomPkg::byteMask               laneEn;

  assign offset   = req.addr[memGeomPkg::offsetBits-1:0];
  assign sizeMask = lsuPkg::alignMask(req.op);
  // extension bit cleared for stores.
  assign sizeOp   = lsuPkg::memOp'({1'b0, req.op[1:0]});

  // copy the low bytes into every slot of their size.
  always_comb begin
    case (sizeOp)
      lsuPkg::lb: repData = {memGeomPkg::laneCount{req.wdata[memGeomPkg::laneBits-1:0]}};
      lsuPkg::lh: repData = {(memGeomPkg::laneCount / 2){req.wdata[2*memGeomPkg::laneBits-1:0]}};
      lsuPkg::lw: repData = {(memGeomPkg::laneCount / 4){req.wdata[4*memGeomPkg::laneBits-1:0]}};
      default:    repData = req.wdata;
    endcase
  end

  // lane enabled when it agrees with the offset above the size bits.
  always_comb begin
    logic [memGeomPkg::offsetBits-1:0] laneIdx;
    for (int lane = 0; lane < memGeomPkg::laneCount; lane++) begin
      laneIdx      = lane[memGeomPkg::offsetBits-1:0];
      laneEn[lane] = ((laneIdx ^ offset) & ~sizeMask) == '0;
    end
  end

  // word index straight from the address.
  always_comb begin
    beat.we    = req.wr;
    beat.index = req.addr[memGeomPkg::offsetBits +: memGeomPkg::indexBits];
    beat.mask  = laneEn;
    beat.data  = repData;
  end

  // misaligned stores are outside this design.
  always_comb begin
    if (req.wr) begin
      assert ((offset & sizeMask) == '0)
        else $error("misaligned store, addr %h op %0d", req.addr, req.op);
      // the core never reads and writes in one cycle.
      assert (!req.rd)
        else $error("rd and wr both high, addr %h", req.addr);
    end
  end

endmodule

// ==== src/dataRam.sv ====
`timescale 1ns/1ns

module dataRam (
  input  logic                             clk,
  input  logic                             arstN,
  input  lsuPkg::storeBeat                 beat,
  input  logic [memGeomPkg::indexBits-1:0] rdIndex,
  output logic [memGeomPkg::wordBits-1:0]  rdWord
);

  // word storage, contents undefined after reset.
  logic [memGeomPkg::wordBits-1:0] mem [memGeomPkg::ramDepth];

  // write port.
  // only enabled lanes change, the rest keep their bytes.
  always_ff @(posedge clk) begin
    if (beat.we) begin
      for (int lane = 0; lane < memGeomPkg::laneCount; lane++) begin
        if (beat.mask[lane]) begin
          mem[beat.index][lane*memGeomPkg::laneBits +: memGeomPkg::laneBits] <=
            beat.data[lane*memGeomPkg::laneBits +: memGeomPkg::laneBits];
        end
      end
    end
  end

  // read port, registered every cycle.
  // samples the word before this edge's write, so read-first.
  always_ff @(posedge clk) begin
    rdWord <= mem[rdIndex];
  end

  // a write strobe with no lane means the mask logic lost the access.
  assert property (@(posedge clk) disable iff (!arstN)
    beat.we |-> beat.mask != '0)
    else $error("write with empty byte mask at index %0d", beat.index);

endmodule

// ==== src/loadAlign.sv ====
`timescale 1ns/1ns

module loadAlign (
  input  logic                            clk,
  input  logic                            arstN,
  input  lsuPkg::lsuReq                   req,
  input  logic [memGeomPkg::wordBits-1:0] rdWord,
  output logic [memGeomPkg::wordBits-1:0] rdData,
  output logic                            rdValid
);

  localparam int lb = memGeomPkg::laneBits;
  localparam int wb = memGeomPkg::wordBits;
  localparam int ob = memGeomPkg::offsetBits;

  // opcode and offset of the read in flight.
  lsuPkg::memOp  opQ;
  logic [ob-1:0] offsetQ;
  logic          validQ;
  // candidate lanes picked from the read word.
  logic [lb-1:0]   byteSel;
  logic [2*lb-1:0] halfSel;
  logic [4*lb-1:0] wordSel;

  // valid follows rd one cycle later.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= req.rd;
    end
  end

  // aligned with the RAM read register.
  always_ff @(posedge clk) begin
    if (req.rd) begin
      opQ     <= req.op;
      offsetQ <= req.addr[ob-1:0];
    end
  end

  // lane select by offset, low bits ignored for wider sizes.
  assign byteSel = rdWord[offsetQ*lb +: lb];
  assign halfSel = rdWord[offsetQ[ob-1:1]*(2*lb) +: 2*lb];
  assign wordSel = rdWord[offsetQ[ob-1]*(4*lb) +: 4*lb];

  // u variants zero-extend, the rest sign-extend.
  always_comb begin
    case (opQ)
      lsuPkg::lb:  rdData = {{(wb-lb){byteSel[lb-1]}}, byteSel};
      lsuPkg::lh:  rdData = {{(wb-2*lb){halfSel[2*lb-1]}}, halfSel};
      lsuPkg::lw:  rdData = {{(wb-4*lb){wordSel[4*lb-1]}}, wordSel};
      lsuPkg::lbu: rdData = {{(wb-lb){1'b0}}, byteSel};
      lsuPkg::lhu: rdData = {{(wb-2*lb){1'b0}}, halfSel};
      lsuPkg::lwu: rdData = {{(wb-4*lb){1'b0}}, wordSel};
      lsuPkg::ld:  rdData = rdWord;
      default:     rdData = rdWord;
    endcase
  end

  assign rdValid = validQ;

  // misaligned loads would straddle lanes.
  assert property (@(posedge clk) disable iff (!arstN)
    req.rd |-> (req.addr[ob-1:0] & lsuPkg::alignMask(req.op)) == '0)
    else $error("misaligned load, addr %h op %0d", req.addr, req.op);

endmodule

// ==== src/lsuTop.sv ====
`timescale 1ns/1ns

module lsuTop (
  input  logic                            clk,
  input  logic                            arstN,
  input  lsuPkg::lsuReq                   req,
  output logic [memGeomPkg::wordBits-1:0] rdData,
  output logic                            rdValid
);

  // aligned store toward the RAM.
  lsuPkg::storeBeat                 beat;
  // registered RAM word, one cycle after rd.
  logic [memGeomPkg::wordBits-1:0]  rdWord;
  logic [memGeomPkg::indexBits-1:0] rdIndex;

  // same word index as the store path.
  assign rdIndex = req.addr[memGeomPkg::offsetBits +: memGeomPkg::indexBits];

  // input side.
  storeAlign uStoreAlign (
    .req  (req),
    .beat (beat)
  );

  // byte-enabled storage.
  dataRam uDataRam (
    .clk     (clk),
    .arstN   (arstN),
    .beat    (beat),
    .rdIndex (rdIndex),
    .rdWord  (rdWord)
  );

  // output side, lane select and extension.
  loadAlign uLoadAlign (
    .clk     (clk),
    .arstN   (arstN),
    .req     (req),
    .rdWord  (rdWord),
    .rdData  (rdData),
    .rdValid (rdValid)
  );

endmodule

// ==== test/lsuTb.sv ====
`timescale 1ns/1ns

module lsuTb;

  localparam int clkPeriod = 100;
  // cycles the read pipeline may need to empty.
  localparam int drainLimit = 8;

  logic                            clk;
  logic                            arstN;
  lsuPkg::lsuReq                   req;
  logic [memGeomPkg::wordBits-1:0] rdData;
  logic                            rdValid;

  // model of the RAM, updated when a store is driven.
  logic [memGeomPkg::wordBits-1:0] shadow [memGeomPkg::ramDepth];
  logic [15:0] lfsr;
  int errCount;
  int timeoutCount;
  int readCount;

  // expected load result, set in the cycle the read is driven.
  logic                            pendValid;
  logic [memGeomPkg::wordBits-1:0] pendData;
  int                              pendTest;
  // one stage later, lined up with rdValid.
  logic                            expValid = 1'b0;
  logic [memGeomPkg::wordBits-1:0] expData = '0;
  int                              expTest = 0;

  lsuTop uut (
    .clk     (clk),
    .arstN   (arstN),
    .req     (req),
    .rdData  (rdData),
    .rdValid (rdValid)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clkPeriod / 2) clk = ~clk;
    end
  end

  always @(posedge clk) begin
    expValid <= pendValid;
    expData  <= pendData;
    expTest  <= pendTest;
  end

  // 16-bit fibonacci LFSR, taps 16 14 13 11.
  function automatic logic nextBit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  // one LFSR step per bit taken.
  function automatic logic [63:0] randBits(input int count);
    logic [63:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[62:0], nextBit()};
    end
    return value;
  endfunction

  function automatic string testName(input int id);
    case (id)
      1:       return "fillReadback";
      2:       return "extendLanes";
      3:       return "partialStore";
      4:       return "backToBack";
      5:       return "writeThenRead";
      default: return "unknown";
    endcase
  endfunction

  // any load opcode, the unused code folds onto ld.
  function automatic lsuPkg::memOp randLoadOp();
    logic [2:0] pick;
    pick = 3'(randBits(3));
    if (pick == 3'b111) begin
      pick = 3'b011;
    end
    return lsuPkg::memOp'(pick);
  endfunction

  // store size only, extension bit clear.
  function automatic lsuPkg::memOp randStoreOp();
    logic [2:0] pick;
    pick = {1'b0, 2'(randBits(2))};
    return lsuPkg::memOp'(pick);
  endfunction

  // round the offset down to a multiple of the access size.
  function automatic logic [2:0] alignOffset(input lsuPkg::memOp op, input logic [2:0] offset);
    int sizeBytes;
    sizeBytes = 1 << op[1:0];
    return 3'((int'(offset) / sizeBytes) * sizeBytes);
  endfunction

  // store writes its low bytes into the lanes from offset upward.
  function automatic void applyStore(input lsuPkg::memOp op, input logic [7:0] index,
                                     input logic [2:0] offset, input logic [63:0] data);
    int sizeBytes;
    sizeBytes = 1 << op[1:0];
    for (int b = 0; b < sizeBytes; b++) begin
      shadow[index][8 * (int'(offset) + b) +: 8] = data[8 * b +: 8];
    end
  endfunction

  // lane from offset, then zero or sign fill above it.
  function automatic logic [63:0] expectLoad(input lsuPkg::memOp op, input logic [63:0] word,
                                             input logic [2:0] offset);
    int          sizeBits;
    logic [63:0] keep;
    logic [63:0] lane;
    logic        zeroExt;
    sizeBits = 8 << op[1:0];
    if (sizeBits == 64) begin
      return word;
    end
    zeroExt = (op == lsuPkg::lbu) || (op == lsuPkg::lhu) || (op == lsuPkg::lwu);
    keep    = (64'd1 << sizeBits) - 64'd1;
    lane    = (word >> (8 * int'(offset))) & keep;
    if (!zeroExt && lane[sizeBits-1]) begin
      lane = lane | ~keep;
    end
    return lane;
  endfunction

  task automatic driveStore(input lsuPkg::memOp op, input logic [7:0] index,
                            input logic [2:0] offset, input logic [63:0] data);
    lsuPkg::lsuReq next;
    next       = '0;
    next.wr    = 1'b1;
    next.op    = op;
    next.addr[memGeomPkg::offsetBits +: memGeomPkg::indexBits] = index;
    next.addr[memGeomPkg::offsetBits-1:0] = offset;
    next.wdata = data;
    @(posedge clk);
    req       <= next;
    pendValid <= 1'b0;
    applyStore(op, index, offset, data);
  endtask

  task automatic driveLoad(input lsuPkg::memOp op, input logic [7:0] index,
                           input logic [2:0] offset, input int test);
    lsuPkg::lsuReq next;
    next    = '0;
    next.rd = 1'b1;
    next.op = op;
    next.addr[memGeomPkg::offsetBits +: memGeomPkg::indexBits] = index;
    next.addr[memGeomPkg::offsetBits-1:0] = offset;
    @(posedge clk);
    req       <= next;
    pendValid <= 1'b1;
    pendData  <= expectLoad(op, shadow[index], offset);
    pendTest  <= test;
    readCount++;
  endtask

  task automatic driveIdle();
    @(posedge clk);
    req       <= '0;
    pendValid <= 1'b0;
  endtask

  // idle the bus and wait for the last load to leave.
  task automatic waitDrained(input string after);
    int cycles;
    cycles = 0;
    driveIdle();
    @(negedge clk);
    while ((rdValid || expValid || pendValid) && cycles < drainLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (rdValid || expValid || pendValid) begin
      timeoutCount++;
      $display("Timeout: read pipeline still busy %0d cycles after %s", cycles, after);
    end
  endtask

  // valid exactly one cycle after each rd.
  assert property (@(posedge clk) disable iff (!arstN) rdValid == expValid)
    else begin
      errCount++;
      $display("Error validTiming: expected rdValid %0b, actual %0b",
               $sampled(expValid), $sampled(rdValid));
    end

  // load data against the shadow memory.
  assert property (@(posedge clk) disable iff (!arstN) expValid |-> rdData == expData)
    else begin
      errCount++;
      $display("Error %s: expected %h, actual %h", testName($sampled(expTest)),
               $sampled(expData), $sampled(rdData));
    end

  initial begin
    lsuPkg::memOp op;
    lsuPkg::memOp rdOp;
    logic [7:0]   index;
    logic [2:0]   offset;
    arstN        = 1'b0;
    req          = '0;
    lfsr         = 16'd38;
    errCount     = 0;
    timeoutCount = 0;
    readCount    = 0;
    pendValid    = 1'b0;
    pendData     = '0;
    pendTest     = 0;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;

    // every word gets a doubleword, then read back in a burst.
    for (int i = 0; i < memGeomPkg::ramDepth; i++) begin
      driveStore(lsuPkg::ld, 8'(i), 3'd0, randBits(64));
    end
    for (int i = 0; i < memGeomPkg::ramDepth; i++) begin
      driveLoad(lsuPkg::ld, 8'(i), 3'd0, 1);
    end
    waitDrained("fill readback");

    // mixed sign bits in bytes, halves and words.
    driveStore(lsuPkg::ld, 8'd5, 3'd0, 64'h70E1_F2C3_B485_06A7);
    for (int code = 0; code < 7; code++) begin
      op = lsuPkg::memOp'(3'(code));
      for (int off = 0; off < memGeomPkg::laneCount; off += (1 << op[1:0])) begin
        driveLoad(op, 8'd5, 3'(off), 2);
      end
    end
    waitDrained("lane extension");

    // partial stores, the full word shows untouched lanes.
    repeat (64) begin
      op     = randStoreOp();
      index  = 8'(randBits(8));
      offset = alignOffset(op, 3'(randBits(3)));
      driveStore(op, index, offset, randBits(64));
      driveIdle();
      driveLoad(lsuPkg::ld, index, 3'd0, 3);
    end
    waitDrained("partial stores");

    // one load per cycle, random size and offset.
    repeat (96) begin
      op     = randLoadOp();
      index  = 8'(randBits(8));
      offset = alignOffset(op, 3'(randBits(3)));
      driveLoad(op, index, offset, 4);
    end
    waitDrained("back-to-back loads");

    // load right behind the store to the same word.
    repeat (32) begin
      op     = randStoreOp();
      index  = 8'(randBits(8));
      offset = alignOffset(op, 3'(randBits(3)));
      driveStore(op, index, offset, randBits(64));
      rdOp = op;
      if (op != lsuPkg::ld) begin
        rdOp = lsuPkg::memOp'({1'(randBits(1)), op[1:0]});
      end
      driveLoad(rdOp, index, offset, 5);
      driveLoad(lsuPkg::ld, index, 3'd0, 5);
    end
    waitDrained("write then read");

    $display("Checked %0d loads: %0d errors, %0d timeouts", readCount, errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
src/memGeomPkg.sv
src/lsuPkg.sv
src/storeAlign.sv
src/dataRam.sv
src/loadAlign.sv
src/lsuTop.sv
test/lsuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module lsuTb -f vlog.f

./obj_dir/VlsuTb | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run.sh: testbench reported failure, see sim.log"
  exit 1
fi
echo "run.sh: done"
